/* sampleBridge.f */
hdl/sampleBridgePkg.sv
hdl/sampleFramer.sv
hdl/asyncFifo.sv
hdl/frameSummer.sv
hdl/sampleBridge.sv
verification/sampleBridge_checker.sv
verification/sampleBridgeTb.sv

/* Makefile */
# Verilator build and run for the sample bridge testbench

TOP   = sampleBridgeTb
FLIST = sampleBridge.f
LOG   = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f $(FLIST) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "Test completed successfully" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf obj_dir $(LOG)

/* verification/sampleBridgeTb.sv */
/*
 * Sample bridge testbench: two unrelated clocks, write-side model, frame sum
 * reference, compare process and watchdog
 */

`default_nettype none
`timescale 1ns/1ps

module sampleBridgeTb;

    import sampleBridgePkg::*;

    // ============================================================
    // Run constants
    // ============================================================
    localparam int RCLK_NS        = 8;
    localparam int WCLK_NS        = 11;
    localparam int RESET_CYCLES   = 5;                  // rclk cycles with arok low
    localparam int STEADY_STROBES = 4 * FRAME_LEN;
    localparam int FILL_STROBES   = FIFO_DEPTH + 6;     // Overruns a stalled FIFO
    localparam int RANDOM_STROBES = 40 * FRAME_LEN;
    localparam int MAX_GAP        = 3;                  // Idle wclk cycles between strobes
    localparam int PAD_STROBES    = 4 * FRAME_LEN;      // Frame padding allowance
    localparam int TOTAL_STROBES  = STEADY_STROBES + FILL_STROBES + RANDOM_STROBES
                                    + PAD_STROBES;
    localparam int WATCHDOG_NS    = (TOTAL_STROBES * (MAX_GAP + 1) + 2000) * WCLK_NS;
    localparam logic [31:0] SEED  = 32'h8ccb65bc;

    logic                rclk = 1'b0;
    logic                wclk = 1'b0;
    logic                arok;
    logic                sampleStrobe;
    logic [SAMPLE_W-1:0] sampleData;
    logic                sampleReady;
    logic [DROP_W-1:0]   dropCount;
    logic                drainEn;
    logic [SUM_W-1:0]    frameSum;
    logic                frameDone;

    // Write-side model
    logic [SAMPLE_W-1:0] acceptedQ [$];                 // Accepted, not yet summed
    int unsigned         acceptedTotal;
    logic [DROP_W-1:0]   expDrops;                      // Saturates like the DUT
    logic                sawNotReady;
    logic                writesDone;                    // Ends the drainEn toggler

    always #(RCLK_NS / 2) rclk = ~rclk;
    always #(WCLK_NS / 2.0) wclk = ~wclk;               // Unrelated to rclk

    sampleBridge i_dut (
        .rclk         (rclk),
        .wclk         (wclk),
        .arok         (arok),
        .sampleStrobe (sampleStrobe),
        .sampleData   (sampleData),
        .sampleReady  (sampleReady),
        .dropCount    (dropCount),
        .drainEn      (drainEn),
        .frameSum     (frameSum),
        .frameDone    (frameDone)
    );

    // ============================================================
    // Helpers
    // ============================================================
    task automatic failRun(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        if (got !== expected) begin
            failRun($sformatf("ERROR %s: got 0x%0h, expected 0x%0h", name, got, expected));
        end
    endtask

    // Sum of the oldest FRAME_LEN accepted samples
    function automatic logic [SUM_W-1:0] expectedFrameSum();
        logic [SUM_W-1:0] sum;
        sum = '0;
        for (int i = 0; i < FRAME_LEN; i++) begin
            sum = sum + SUM_W'(acceptedQ[i]);
        end
        return sum;
    endfunction

    // Strobe held into the next wclk edge, ready seen here is what the DUT sees
    task automatic strobeSample(input logic [SAMPLE_W-1:0] data);
        @(posedge wclk);
        #1;
        sampleStrobe = 1'b1;
        sampleData   = data;
        if (sampleReady) begin
            acceptedQ.push_back(data);
            acceptedTotal++;
        end else begin
            sawNotReady = 1'b1;
            if (expDrops != '1) begin
                expDrops = expDrops + 1'b1;
            end
        end
    endtask

    task automatic idleWrite(input int cycles);
        repeat (cycles) begin
            @(posedge wclk);
            #1;
            sampleStrobe = 1'b0;
        end
    endtask

    task automatic setDrain(input logic en);
        @(posedge rclk);
        #1;
        drainEn = en;
    endtask

    // Complete the last frame so every accepted sample gets summed
    task automatic padFrame();
        while (acceptedTotal % FRAME_LEN != 0) begin
            strobeSample(SAMPLE_W'($urandom()));
        end
        idleWrite(2);
    endtask

    task automatic waitFramesDone();
        while (acceptedQ.size() != 0) begin
            @(posedge rclk);
        end
        repeat (4) @(posedge rclk);
    endtask

    task automatic checkDrops();
        idleWrite(2);                                   // Last drop edge has passed
        checkValue("dropCount", 32'(dropCount), 32'(expDrops));
    endtask

    // ============================================================
    // Compare process
    // ============================================================
    // Sum and done are stable by the falling edge
    always @(negedge rclk) begin
        if (arok === 1'b1 && frameDone === 1'b1) begin
            if (acceptedQ.size() < FRAME_LEN) begin
                failRun("frameDone pulsed without a full frame of accepted samples");
            end else begin
                checkValue("frameSum", 32'(frameSum), 32'(expectedFrameSum()));
                repeat (FRAME_LEN) void'(acceptedQ.pop_front());
            end
        end
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        failRun("Timeout: frames stopped arriving before all samples were summed");
    end

    // ============================================================
    // Stimulus
    // ============================================================
    initial begin
        arok          = 1'b0;
        sampleStrobe  = 1'b0;
        sampleData    = '0;
        drainEn       = 1'b0;
        acceptedTotal = 0;
        expDrops      = '0;
        sawNotReady   = 1'b0;
        writesDone    = 1'b0;
        void'($urandom(SEED));

        repeat (RESET_CYCLES) @(posedge rclk);
        #1;
        arok = 1'b1;
        idleWrite(4);                                   // Let wclk reset syncs release

        // Reset state
        checkValue("frameDone", 32'(frameDone), 32'(0));
        checkValue("dropCount", 32'(dropCount), 32'(0));
        checkValue("sampleReady", 32'(sampleReady), 32'(1));

        // Steady stream, drain on
        setDrain(1'b1);
        for (int i = 0; i < STEADY_STROBES; i++) begin
            strobeSample(SAMPLE_W'(i * 293 + 17));
        end
        idleWrite(2);
        padFrame();
        waitFramesDone();

        // Fill with the consumer stalled, overflow gets dropped
        setDrain(1'b0);
        repeat (4) @(posedge rclk);
        sawNotReady = 1'b0;
        for (int i = 0; i < FILL_STROBES; i++) begin
            strobeSample(SAMPLE_W'($urandom()));
        end
        idleWrite(2);
        checkValue("sampleReady fell", 32'(sawNotReady), 32'(1));
        checkDrops();

        // Drain the backlog
        setDrain(1'b1);
        padFrame();
        waitFramesDone();

        // Random gaps with drainEn toggling
        fork
            begin
                for (int n = 0; n < RANDOM_STROBES; n++) begin
                    idleWrite($urandom_range(0, MAX_GAP));
                    strobeSample(SAMPLE_W'($urandom()));
                end
                idleWrite(1);
                writesDone = 1'b1;
            end
            begin
                while (!writesDone) begin
                    setDrain(~drainEn);
                    repeat ($urandom_range(5, 40)) @(posedge rclk);
                end
            end
        join
        setDrain(1'b1);
        padFrame();
        waitFramesDone();

        // Final checks
        checkDrops();
        checkValue("sampleReady", 32'(sampleReady), 32'(1));   // Drained FIFO has room
        if (i_dut.uChecker.assertFails == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            failRun("A concurrent assertion in the bound checker failed");
        end
    end

endmodule : sampleBridgeTb

`default_nettype wire

/* verification/sampleBridge_checker.sv */
/*
 * Sample bridge checker: done pulse width, drop counter growth and quiet done during reset
 */

`default_nettype none
`timescale 1ns/1ps

module sampleBridge_checker (
    input wire logic                               rclk,
    input wire logic                               wclk,
    input wire logic                               arok,
    input wire logic                               frameDone,
    input wire logic [sampleBridgePkg::DROP_W-1:0] dropCount
);

    int unsigned assertFails = 0;                       // Failed assertion count

    // Done is a one-cycle pulse
    donePulse: assert property (@(posedge rclk) disable iff (!arok) frameDone |=> !frameDone)
        else begin
            assertFails = assertFails + 1;
            $error("frameDone high on two consecutive rclk edges");
        end

    // Drop counter only grows or saturates
    dropMonotonic: assert property (@(posedge wclk) disable iff (!arok)
                                    dropCount >= $past(dropCount))
        else begin
            assertFails = assertFails + 1;
            $error("dropCount decreased");
        end

    // No done pulse while reset is held
    resetQuiet: assert property (@(posedge rclk) !arok |-> !frameDone)
        else begin
            assertFails = assertFails + 1;
            $error("frameDone high during reset");
        end

endmodule : sampleBridge_checker

bind sampleBridge sampleBridge_checker uChecker (
    .rclk      (rclk),
    .wclk      (wclk),
    .arok      (arok),
    .frameDone (frameDone),
    .dropCount (dropCount)
);

`default_nettype wire

/* hdl/sampleBridge.sv */
/*
 * Sample bridge top: wclk producer, async FIFO and rclk frame summer
 */

`default_nettype none
`timescale 1ns/1ps

module sampleBridge (
    input  wire logic                                 rclk,
    input  wire logic                                 wclk,
    input  wire logic                                 arok,           // Async, active low
    // Write side, wclk domain
    input  wire logic                                 sampleStrobe,
    input  wire logic [sampleBridgePkg::SAMPLE_W-1:0] sampleData,
    output logic                                      sampleReady,    // FIFO not full
    output logic      [sampleBridgePkg::DROP_W-1:0]   dropCount,
    // Read side, rclk domain
    input  wire logic                                 drainEn,
    output logic      [sampleBridgePkg::SUM_W-1:0]    frameSum,
    output logic                                      frameDone
);

    import sampleBridgePkg::*;

    // Producer to FIFO
    logic                wtrigger;
    logic [SAMPLE_W-1:0] wdata;
    logic                wok;

    // FIFO to consumer
    logic                rtrigger;
    logic [SAMPLE_W-1:0] rdata;
    logic                rok;

    assign sampleReady = wok;

    // ============================================================
    // Write domain producer
    // ============================================================
    sampleFramer uFramer (
        .wclk         (wclk),
        .arok         (arok),
        .sampleStrobe (sampleStrobe),
        .sampleData   (sampleData),
        .wok          (wok),
        .wtrigger     (wtrigger),
        .wdata        (wdata),
        .dropCount    (dropCount)
    );

    // Clock crossing
    asyncFifo uFifo (
        .wclk     (wclk),
        .rclk     (rclk),
        .arok     (arok),
        .wtrigger (wtrigger),
        .wdata    (wdata),
        .wok      (wok),
        .rtrigger (rtrigger),
        .rdata    (rdata),
        .rok      (rok)
    );

    // ============================================================
    // Read domain consumer
    // ============================================================
    frameSummer uSummer (
        .rclk      (rclk),
        .arok      (arok),
        .rdata     (rdata),
        .rok       (rok),
        .drainEn   (drainEn),
        .rtrigger  (rtrigger),
        .frameSum  (frameSum),
        .frameDone (frameDone)
    );

endmodule : sampleBridge

`default_nettype wire

/* hdl/frameSummer.sv */
/*
 * Frame summer: read-side consumer, drains the FIFO and publishes the sum
 * of every FRAME_LEN samples with a one-cycle done pulse
 */

`default_nettype none
`timescale 1ns/1ps

module frameSummer (
    input  wire logic                                 rclk,
    input  wire logic                                 arok,       // Async, active low
    input  wire logic [sampleBridgePkg::SAMPLE_W-1:0] rdata,
    input  wire logic                                 rok,
    input  wire logic                                 drainEn,    // Outside permits reads
    output logic                                      rtrigger,
    output logic      [sampleBridgePkg::SUM_W-1:0]    frameSum,
    output logic                                      frameDone
);

    import sampleBridgePkg::*;

    sumState_e                      state;
    logic [SUM_W-1:0]               acc;            // Running frame sum
    logic [$clog2(FRAME_LEN)-1:0]   readCnt;        // Reads so far in this frame
    logic                           rFire;          // Read accepted this edge
    logic                           lastRead;       // Final sample of the frame

    // ============================================================
    // Read strobe
    // ============================================================
    // Held off during the done pulse so the next frame starts after it
    assign rtrigger = (state == SUM_ACC) & drainEn & ~frameDone;
    assign rFire    = rtrigger & rok;
    assign lastRead = rFire && (readCnt == FRAME_LEN - 1);

    // ============================================================
    // Control FSM and accumulator
    // ============================================================
    always_ff @(posedge rclk or negedge arok) begin
        if (!arok) begin
            state     <= SUM_IDLE;
            acc       <= '0;
            readCnt   <= '0;
            frameDone <= 1'b0;
        end else begin
            frameDone <= 1'b0;                      // Pulse by default off
            case (state)
                SUM_IDLE: begin
                    acc     <= '0;
                    readCnt <= '0;
                    state   <= SUM_ACC;
                end
                SUM_ACC: begin
                    if (rFire) begin
                        acc     <= acc + {{(SUM_W-SAMPLE_W){1'b0}}, rdata};
                        readCnt <= readCnt + 1'b1;  // Wraps to zero on the last read
                    end
                    if (lastRead) begin
                        state <= SUM_EMIT;
                    end
                end
                SUM_EMIT: begin
                    frameDone <= 1'b1;              // One rclk cycle
                    acc       <= '0;                // Fresh frame
                    state     <= SUM_ACC;
                end
                default: state <= SUM_IDLE;
            endcase
        end
    end

    // Sum register, valid while frameDone is high
    always_ff @(posedge rclk) begin
        if (state == SUM_EMIT) begin
            frameSum <= acc;
        end
    end

endmodule : frameSummer

`default_nettype wire

/* hdl/asyncFifo.sv */
/*
 * Async FIFO: dual-clock sample store with Gray pointers, two-flop pointer
 * synchronizers and registered empty/full flags
 */

`default_nettype none
`timescale 1ns/1ps

module asyncFifo (
    input  wire logic                                 wclk,
    input  wire logic                                 rclk,
    input  wire logic                                 arok,       // Async, active low
    // Write side
    input  wire logic                                 wtrigger,
    input  wire logic [sampleBridgePkg::SAMPLE_W-1:0] wdata,
    output logic                                      wok,        // Not full
    // Read side
    input  wire logic                                 rtrigger,
    output logic      [sampleBridgePkg::SAMPLE_W-1:0] rdata,      // Oldest entry
    output logic                                      rok         // Not empty
);

    import sampleBridgePkg::*;

    // Binary to reflected Gray code
    function automatic logic [PTR_W-1:0] bin2gray(input logic [PTR_W-1:0] bin);
        return bin ^ (bin >> 1);
    endfunction

    logic [SAMPLE_W-1:0] mem [FIFO_DEPTH];  // Storage, no reset
    logic [PTR_W-1:0]    rBin, rGray;       // Read pointer, both codes

    // ============================================================
    // Write domain
    // ============================================================
    logic [1:0]       wRstSync;                 // Reset release chain
    logic             wRstN;
    logic [PTR_W-1:0] wBin, wGray;              // Write pointer, both codes
    logic [PTR_W-1:0] wBinNext, wGrayNext;
    logic [PTR_W-1:0] rGraySync1, rGraySync2;   // Read pointer seen in wclk
    logic             wFire;                    // Write this edge
    logic             fullNext;

    always_ff @(posedge wclk or negedge arok) begin
        if (!arok) begin
            wRstSync <= 2'b00;
        end else begin
            wRstSync <= {wRstSync[0], 1'b1};
        end
    end

    assign wRstN = wRstSync[1];

    assign wFire     = wtrigger & wok;
    assign wBinNext  = wBin + {{(PTR_W-1){1'b0}}, wFire};
    assign wGrayNext = bin2gray(wBinNext);

    // Full when writer is one lap ahead: top two Gray bits differ, rest equal
    assign fullNext = (wGrayNext == {~rGraySync2[PTR_W-1:PTR_W-2],
                                     rGraySync2[PTR_W-3:0]});

    always_ff @(posedge wclk) begin
        if (wFire) begin
            mem[wBin[PTR_W-2:0]] <= wdata;      // Wrap bit not part of the address
        end
    end

    always_ff @(posedge wclk or negedge wRstN) begin
        if (!wRstN) begin
            wBin       <= '0;
            wGray      <= '0;
            rGraySync1 <= '0;
            rGraySync2 <= '0;
            wok        <= 1'b1;                 // Room for writes out of reset
        end else begin
            wBin       <= wBinNext;
            wGray      <= wGrayNext;
            rGraySync1 <= rGray;                // Crosses from rclk
            rGraySync2 <= rGraySync1;
            wok        <= ~fullNext;
        end
    end

    // ============================================================
    // Read domain
    // ============================================================
    logic [PTR_W-1:0] rBinNext, rGrayNext;
    logic [PTR_W-1:0] wGraySync1, wGraySync2;   // Write pointer seen in rclk
    logic             rFire;                    // Read this edge
    logic             emptyNext;

    assign rFire     = rtrigger & rok;
    assign rBinNext  = rBin + {{(PTR_W-1){1'b0}}, rFire};
    assign rGrayNext = bin2gray(rBinNext);

    // Empty when both pointers match, wrap bit included
    assign emptyNext = (rGrayNext == wGraySync2);

    always_ff @(posedge rclk or negedge arok) begin
        if (!arok) begin
            rBin       <= '0;
            rGray      <= '0;
            wGraySync1 <= '0;
            wGraySync2 <= '0;
            rok        <= 1'b0;                 // Nothing to read out of reset
        end else begin
            rBin       <= rBinNext;
            rGray      <= rGrayNext;
            wGraySync1 <= wGray;                // Crosses from wclk
            wGraySync2 <= wGraySync1;
            rok        <= ~emptyNext;
        end
    end

    // First-word fall-through
    assign rdata = mem[rBin[PTR_W-2:0]];

endmodule : asyncFifo

`default_nettype wire

/* hdl/sampleFramer.sv */
/*
 * Sample framer: write-side producer, pushes strobed samples into the FIFO
 * and counts the ones refused while it is full
 */

`default_nettype none
`timescale 1ns/1ps

module sampleFramer (
    input  wire logic                                 wclk,
    input  wire logic                                 arok,          // Async, active low
    input  wire logic                                 sampleStrobe,
    input  wire logic [sampleBridgePkg::SAMPLE_W-1:0] sampleData,
    input  wire logic                                 wok,           // FIFO has space
    output logic                                      wtrigger,
    output logic      [sampleBridgePkg::SAMPLE_W-1:0] wdata,
    output logic      [sampleBridgePkg::DROP_W-1:0]   dropCount
);

    // ============================================================
    // Reset release into wclk
    // ============================================================
    logic [1:0] wRstSync;                   // Two-flop release chain
    logic       wRstN;                      // Synchronized reset, active low

    // Assert asynchronously, release on the second wclk edge
    always_ff @(posedge wclk or negedge arok) begin
        if (!arok) begin
            wRstSync <= 2'b00;
        end else begin
            wRstSync <= {wRstSync[0], 1'b1};
        end
    end

    assign wRstN = wRstSync[1];

    // ============================================================
    // Write strobe
    // ============================================================
    // Sample accepted on the same edge it is strobed
    assign wtrigger = sampleStrobe & wok;   // No write while full
    assign wdata    = sampleData;           // FIFO latches it on the write edge

    // ============================================================
    // Drop counter
    // ============================================================
    logic dropEvent;                        // Strobe hit a full FIFO
    logic dropSat;                          // Counter at its ceiling

    assign dropEvent = sampleStrobe & ~wok;
    assign dropSat   = &dropCount;

    always_ff @(posedge wclk or negedge wRstN) begin
        if (!wRstN) begin
            dropCount <= '0;
        end else if (dropEvent && !dropSat) begin
            dropCount <= dropCount + 1'b1;  // Sticks at all ones
        end
    end

endmodule : sampleFramer

`default_nettype wire

/* hdl/sampleBridgePkg.sv */
/*
 * Sample bridge package: shared widths, FIFO sizing, frame length and consumer states
 */

`default_nettype none

package sampleBridgePkg;

    // ============================================================
    // Data path
    // ============================================================
    localparam int SAMPLE_W = 12;   // One sample, also the FIFO word
    localparam int SUM_W    = 16;   // Eight full-scale samples fit without overflow

    // ============================================================
    // FIFO sizing
    // ============================================================
    // Depth must stay a power of two for the Gray pointer scheme
    localparam int FIFO_DEPTH = 8;
    localparam int PTR_W      = 4;  // Address bits plus one wrap bit

    // ============================================================
    // Framing and statistics
    // ============================================================
    localparam int FRAME_LEN = 8;   // Samples per frame sum
    localparam int DROP_W    = 8;   // Saturating drop counter

    // Consumer FSM states
    typedef enum logic [1:0] {
        SUM_IDLE = 2'd0,            // Just out of reset
        SUM_ACC  = 2'd1,            // Draining and accumulating
        SUM_EMIT = 2'd2             // Frame complete, publish sum
    } sumState_e;

endpackage : sampleBridgePkg

`default_nettype wire
